/* periph_pkg.sv */
// ####################################################################
// Peripheral subsystem shared definitions
// Bus structs, register maps and interrupt source numbering
// ####################################################################
package periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_resp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Address map
  localparam int NumPeriph    = 3;
  localparam int PeriphSelMsb = 11;
  localparam int PeriphSelLsb = 8;
  localparam int RegOffW      = 8;

  localparam logic [31:0] UnmappedRdata = 32'h0000_0000;

  typedef enum logic [1:0] {
    IDX_IRQ   = 2'd0,
    IDX_GPIO  = 2'd1,
    IDX_TIMER = 2'd2
  } periph_idx_e;

  typedef enum logic [RegOffW-1:0] {
    IRQ_PENDING = 8'h00,
    IRQ_ENABLE  = 8'h04,
    IRQ_CLAIM   = 8'h08,
    IRQ_MSIP    = 8'h0C
  } irq_reg_e;

  typedef enum logic [RegOffW-1:0] {
    GPIO_IN          = 8'h00,
    GPIO_OUT         = 8'h04,
    GPIO_OE          = 8'h08,
    GPIO_INTR_EN     = 8'h0C,
    GPIO_INTR_STATUS = 8'h10
  } gpio_reg_e;

  typedef enum logic [RegOffW-1:0] {
    TMR_CTRL  = 8'h00,
    TMR_MTIME = 8'h04,
    TMR_CMP0  = 8'h08,
    TMR_CMP1  = 8'h0C
  } timer_reg_e;

  // Interrupt sources
  localparam int NumGpio   = 8;
  localparam int NumExtIrq = 4;
  localparam int NumSrc    = 16;
  localparam int SrcIdW    = 4;

  // Sources 0 and 15 are tied to zero
  typedef enum logic [SrcIdW-1:0] {
    IRQ_TIMER0 = 4'd1,
    IRQ_GPIO0  = 4'd3,
    IRQ_EXT0   = 4'd11
  } irq_src_e;

  // Byte-lane merge of write data into a register
  function automatic logic [31:0] apply_wstrb(logic [31:0] cur, logic [31:0] wdata,
                                              logic [3:0] wstrb);
    logic [31:0] res;
    res = cur;
    for (int b = 0; b < 4; b++) begin
      if (wstrb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

/* obi_to_reg.sv */
// ####################################################################
// OBI slave to register-bus bridge
// Response data and error come back one cycle after the grant
// ####################################################################
`timescale 1ns/100ps

module obi_to_reg (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  periph_pkg::obi_req_t  obi_req_i,
  output periph_pkg::obi_resp_t obi_resp_o,
  output periph_pkg::reg_req_t  reg_req_o,
  input  periph_pkg::reg_rsp_t  reg_rsp_i
);

  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  // No back-pressure, every request is granted at once
  always_comb begin
    reg_req_o.valid = obi_req_i.req;
    reg_req_o.write = obi_req_i.we;
    reg_req_o.wstrb = obi_req_i.be;
    reg_req_o.addr  = obi_req_i.addr;
    reg_req_o.wdata = obi_req_i.wdata;

    obi_resp_o.gnt    = obi_req_i.req;
    obi_resp_o.rvalid = rvalid_q;
    obi_resp_o.err    = err_q;
    obi_resp_o.rdata  = rdata_q;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= obi_req_i.req;
      err_q    <= obi_req_i.req & reg_rsp_i.error;
    end
  end

  always_ff @(posedge clk_i) begin
    if (obi_req_i.req) begin
      rdata_q <= reg_rsp_i.rdata;
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_resp_o.gnt |=> obi_resp_o.rvalid);

  // Peripherals answer in the request cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    reg_req_o.valid |-> reg_rsp_i.ready);

endmodule

/* reg_decode_demux.sv */
// ####################################################################
// Register-bus address decoder
// Steers requests by address bits 11:8, errors on unmapped selects
// ####################################################################
`timescale 1ns/100ps

module reg_decode_demux (
  input  periph_pkg::reg_req_t                       reg_req_i,
  output periph_pkg::reg_rsp_t                       reg_rsp_o,
  output periph_pkg::reg_req_t [periph_pkg::NumPeriph-1:0] periph_req_o,
  input  periph_pkg::reg_rsp_t [periph_pkg::NumPeriph-1:0] periph_rsp_i
);

  logic [periph_pkg::PeriphSelMsb-periph_pkg::PeriphSelLsb:0] sel;
  logic                                                       hit;
  periph_pkg::periph_idx_e                                    idx;
  logic [periph_pkg::NumPeriph-1:0]                           periph_valid;

  always_comb begin
    sel = reg_req_i.addr[periph_pkg::PeriphSelMsb:periph_pkg::PeriphSelLsb];
    hit = (sel < 4'(periph_pkg::NumPeriph));
    idx = periph_pkg::periph_idx_e'(sel[1:0]);

    // Payload goes everywhere, only the selected port sees valid
    for (int i = 0; i < periph_pkg::NumPeriph; i++) begin
      periph_req_o[i]       = reg_req_i;
      periph_req_o[i].valid = 1'b0;
    end
    if (hit) begin
      periph_req_o[idx].valid = reg_req_i.valid;
    end

    for (int i = 0; i < periph_pkg::NumPeriph; i++) begin
      periph_valid[i] = periph_req_o[i].valid;
    end

    if (hit) begin
      reg_rsp_o = periph_rsp_i[idx];
    end else begin
      reg_rsp_o.ready = 1'b1;
      reg_rsp_o.error = 1'b1;
      reg_rsp_o.rdata = periph_pkg::UnmappedRdata;
    end

    assert ($onehot0(periph_valid));
  end

endmodule

/* irq_ctrl.sv */
// ####################################################################
// Interrupt controller
// Edge-captured sources with enable, claim and software interrupt
// ####################################################################
`timescale 1ns/100ps

module irq_ctrl (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  periph_pkg::reg_req_t              reg_req_i,
  output periph_pkg::reg_rsp_t              reg_rsp_o,
  input  logic [periph_pkg::NumSrc-1:0]     src_i,
  output logic                              irq_o,
  output logic                              msip_o,
  output logic [periph_pkg::SrcIdW-1:0]     irq_id_o
);

  logic [periph_pkg::NumSrc-1:0] src_live;
  logic [periph_pkg::NumSrc-1:0] src_q;
  logic [periph_pkg::NumSrc-1:0] src_rise;
  logic [periph_pkg::NumSrc-1:0] pending_q;
  logic [periph_pkg::NumSrc-1:0] enable_q;
  logic [periph_pkg::NumSrc-1:0] pend_en;
  logic [periph_pkg::NumSrc-1:0] claim_clr;
  logic [periph_pkg::SrcIdW-1:0] claim_id;
  logic [periph_pkg::SrcIdW-1:0] id_q;
  logic                          irq_q;
  logic                          msip_q;
  logic                          wr_en;
  logic                          claim_rd;
  periph_pkg::irq_reg_e          offset;

  // First and last source never fire
  always_comb begin
    src_live                       = src_i;
    src_live[0]                    = 1'b0;
    src_live[periph_pkg::NumSrc-1] = 1'b0;
  end

  assign src_rise = src_live & ~src_q;
  assign pend_en  = pending_q & enable_q;

  // Lowest numbered pending and enabled source
  always_comb begin
    claim_id = '0;
    for (int i = periph_pkg::NumSrc - 1; i > 0; i--) begin
      if (pend_en[i]) begin
        claim_id = periph_pkg::SrcIdW'(i);
      end
    end
  end

  assign offset   = periph_pkg::irq_reg_e'(reg_req_i.addr[periph_pkg::RegOffW-1:0]);
  assign wr_en    = reg_req_i.valid & reg_req_i.write;
  assign claim_rd = reg_req_i.valid & ~reg_req_i.write & (offset == periph_pkg::IRQ_CLAIM);

  always_comb begin
    claim_clr = '0;
    if (claim_rd) begin
      claim_clr[claim_id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      src_q     <= '0;
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
      irq_q     <= 1'b0;
      id_q      <= '0;
    end else begin
      src_q     <= src_live;
      // New edge wins over a claim in the same cycle
      pending_q <= (pending_q & ~claim_clr) | src_rise;
      irq_q     <= |pend_en;
      id_q      <= claim_id;
      if (wr_en && offset == periph_pkg::IRQ_ENABLE) begin
        enable_q <= periph_pkg::NumSrc'(periph_pkg::apply_wstrb(32'(enable_q),
                                        reg_req_i.wdata, reg_req_i.wstrb));
      end
      if (wr_en && offset == periph_pkg::IRQ_MSIP && reg_req_i.wstrb[0]) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    reg_rsp_o.rdata = '0;
    case (offset)
      periph_pkg::IRQ_PENDING: reg_rsp_o.rdata = 32'(pending_q);
      periph_pkg::IRQ_ENABLE:  reg_rsp_o.rdata = 32'(enable_q);
      periph_pkg::IRQ_CLAIM:   reg_rsp_o.rdata = 32'(claim_id);
      periph_pkg::IRQ_MSIP:    reg_rsp_o.rdata = 32'(msip_q);
      default:                 reg_rsp_o.rdata = '0;
    endcase
  end

  assign irq_o    = irq_q;
  assign irq_id_o = id_q;
  assign msip_o   = msip_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i) irq_o |-> irq_id_o != '0);

endmodule

/* gpio.sv */
// ####################################################################
// Eight-pin GPIO
// Output, output enable, synchronized input, rising-edge interrupts
// ####################################################################
`timescale 1ns/100ps

module gpio (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  periph_pkg::reg_req_t           reg_req_i,
  output periph_pkg::reg_rsp_t           reg_rsp_o,
  input  logic [periph_pkg::NumGpio-1:0] gpio_i,
  output logic [periph_pkg::NumGpio-1:0] gpio_o,
  output logic [periph_pkg::NumGpio-1:0] gpio_oe_o,
  output logic [periph_pkg::NumGpio-1:0] intr_o
);

  logic [periph_pkg::NumGpio-1:0] sync1_q;
  logic [periph_pkg::NumGpio-1:0] sync2_q;
  logic [periph_pkg::NumGpio-1:0] in_q;
  logic [periph_pkg::NumGpio-1:0] in_rise;
  logic [periph_pkg::NumGpio-1:0] out_q;
  logic [periph_pkg::NumGpio-1:0] oe_q;
  logic [periph_pkg::NumGpio-1:0] intr_en_q;
  logic [periph_pkg::NumGpio-1:0] status_q;
  logic [periph_pkg::NumGpio-1:0] status_clr;
  logic                           wr_lo;
  periph_pkg::gpio_reg_e          offset;

  assign offset  = periph_pkg::gpio_reg_e'(reg_req_i.addr[periph_pkg::RegOffW-1:0]);
  assign wr_lo   = reg_req_i.valid & reg_req_i.write & reg_req_i.wstrb[0];
  assign in_rise = sync2_q & ~in_q;

  // Write 1 to clear
  assign status_clr = (wr_lo && offset == periph_pkg::GPIO_INTR_STATUS) ?
                      reg_req_i.wdata[periph_pkg::NumGpio-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      in_q      <= '0;
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      in_q     <= sync2_q;
      status_q <= (status_q & ~status_clr) | in_rise;
      if (wr_lo) begin
        case (offset)
          periph_pkg::GPIO_OUT:     out_q     <= reg_req_i.wdata[periph_pkg::NumGpio-1:0];
          periph_pkg::GPIO_OE:      oe_q      <= reg_req_i.wdata[periph_pkg::NumGpio-1:0];
          periph_pkg::GPIO_INTR_EN: intr_en_q <= reg_req_i.wdata[periph_pkg::NumGpio-1:0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::GPIO_IN:          reg_rsp_o.rdata = 32'(sync2_q);
      periph_pkg::GPIO_OUT:         reg_rsp_o.rdata = 32'(out_q);
      periph_pkg::GPIO_OE:          reg_rsp_o.rdata = 32'(oe_q);
      periph_pkg::GPIO_INTR_EN:     reg_rsp_o.rdata = 32'(intr_en_q);
      periph_pkg::GPIO_INTR_STATUS: reg_rsp_o.rdata = 32'(status_q);
      default:                      reg_rsp_o.rdata = '0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_oe_o = oe_q;
  assign intr_o    = status_q & intr_en_q;

endmodule

/* cmp_timer.sv */
// ####################################################################
// Compare timer
// Prescaled mtime counter with two level compare interrupts
// ####################################################################
`timescale 1ns/100ps

module cmp_timer (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic [1:0]           intr_o
);

  logic              en_q;
  logic [7:0]        presc_q;
  logic [7:0]        presc_cnt_q;
  logic [31:0]       mtime_q;
  logic [1:0][31:0]  cmp_q;
  logic [1:0]        intr_q;
  logic [31:0]       ctrl_rd;
  logic [31:0]       ctrl_wr;
  logic              tick;
  logic              wr_en;
  periph_pkg::timer_reg_e offset;

  assign offset  = periph_pkg::timer_reg_e'(reg_req_i.addr[periph_pkg::RegOffW-1:0]);
  assign wr_en   = reg_req_i.valid & reg_req_i.write;
  assign ctrl_rd = {16'h0000, presc_q, 7'h00, en_q};
  assign ctrl_wr = periph_pkg::apply_wstrb(ctrl_rd, reg_req_i.wdata, reg_req_i.wstrb);
  // One mtime step every prescale+1 cycles
  assign tick    = en_q & (presc_cnt_q == presc_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q        <= 1'b0;
      presc_q     <= '0;
      presc_cnt_q <= '0;
      mtime_q     <= '0;
      cmp_q       <= '1;
      intr_q      <= '0;
    end else begin
      if (!en_q || tick) begin
        presc_cnt_q <= '0;
      end else begin
        presc_cnt_q <= presc_cnt_q + 8'd1;
      end
      // Software write beats the increment
      if (wr_en && offset == periph_pkg::TMR_MTIME) begin
        mtime_q <= periph_pkg::apply_wstrb(mtime_q, reg_req_i.wdata, reg_req_i.wstrb);
      end else if (tick) begin
        mtime_q <= mtime_q + 32'd1;
      end
      if (wr_en) begin
        case (offset)
          periph_pkg::TMR_CTRL: begin
            en_q    <= ctrl_wr[0];
            presc_q <= ctrl_wr[15:8];
          end
          periph_pkg::TMR_CMP0:
            cmp_q[0] <= periph_pkg::apply_wstrb(cmp_q[0], reg_req_i.wdata, reg_req_i.wstrb);
          periph_pkg::TMR_CMP1:
            cmp_q[1] <= periph_pkg::apply_wstrb(cmp_q[1], reg_req_i.wdata, reg_req_i.wstrb);
          default: ;
        endcase
      end
      for (int k = 0; k < 2; k++) begin
        intr_q[k] <= (mtime_q >= cmp_q[k]);
      end
    end
  end

  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b0;
    case (offset)
      periph_pkg::TMR_CTRL:  reg_rsp_o.rdata = ctrl_rd;
      periph_pkg::TMR_MTIME: reg_rsp_o.rdata = mtime_q;
      periph_pkg::TMR_CMP0:  reg_rsp_o.rdata = cmp_q[0];
      periph_pkg::TMR_CMP1:  reg_rsp_o.rdata = cmp_q[1];
      default:               reg_rsp_o.rdata = '0;
    endcase
  end

  assign intr_o = intr_q;

endmodule

/* peripheral_subsystem.sv */
// ####################################################################
// Peripheral subsystem top
// OBI bridge, decoder, interrupt controller, GPIO and compare timer
// ####################################################################
`timescale 1ns/100ps

module peripheral_subsystem (
  input  logic                             clk_i,
  input  logic                             rst_n_i,
  input  periph_pkg::obi_req_t             obi_req_i,
  output periph_pkg::obi_resp_t            obi_resp_o,
  input  logic [periph_pkg::NumExtIrq-1:0] irq_ext_i,
  output logic                             irq_o,
  output logic                             msip_o,
  input  logic [periph_pkg::NumGpio-1:0]   gpio_i,
  output logic [periph_pkg::NumGpio-1:0]   gpio_o,
  output logic [periph_pkg::NumGpio-1:0]   gpio_oe_o,
  output logic [1:0]                       timer_intr_o
);

  periph_pkg::reg_req_t                            periph_req;
  periph_pkg::reg_rsp_t                            periph_rsp;
  periph_pkg::reg_req_t [periph_pkg::NumPeriph-1:0] slv_req;
  periph_pkg::reg_rsp_t [periph_pkg::NumPeriph-1:0] slv_rsp;
  logic [periph_pkg::NumGpio-1:0]                  gpio_intr;
  logic [periph_pkg::NumSrc-1:0]                   intr_vector;

  // Sources 0 and 15 stay low
  always_comb begin
    intr_vector = '0;
    intr_vector[periph_pkg::IRQ_TIMER0 +: 2]                   = timer_intr_o;
    intr_vector[periph_pkg::IRQ_GPIO0 +: periph_pkg::NumGpio]  = gpio_intr;
    intr_vector[periph_pkg::IRQ_EXT0 +: periph_pkg::NumExtIrq] = irq_ext_i;
  end

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .rst_n_i,
    .obi_req_i,
    .obi_resp_o,
    .reg_req_o (periph_req),
    .reg_rsp_i (periph_rsp)
  );

  reg_decode_demux reg_decode_demux_i (
    .reg_req_i    (periph_req),
    .reg_rsp_o    (periph_rsp),
    .periph_req_o (slv_req),
    .periph_rsp_i (slv_rsp)
  );

  irq_ctrl irq_ctrl_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[periph_pkg::IDX_IRQ]),
    .reg_rsp_o (slv_rsp[periph_pkg::IDX_IRQ]),
    .src_i     (intr_vector),
    .irq_o,
    .msip_o,
    .irq_id_o  ()
  );

  gpio gpio_blk_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[periph_pkg::IDX_GPIO]),
    .reg_rsp_o (slv_rsp[periph_pkg::IDX_GPIO]),
    .gpio_i,
    .gpio_o,
    .gpio_oe_o,
    .intr_o    (gpio_intr)
  );

  cmp_timer cmp_timer_i (
    .clk_i,
    .rst_n_i,
    .reg_req_i (slv_req[periph_pkg::IDX_TIMER]),
    .reg_rsp_o (slv_rsp[periph_pkg::IDX_TIMER]),
    .intr_o    (timer_intr_o)
  );

endmodule

/* tb_checker.sv */
// ####################################################################
// Testbench checker for the peripheral subsystem
// Compares read responses and output levels with expected values
// ####################################################################
`timescale 1ns/100ps

module tb_checker (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  req_i,
  input  periph_pkg::obi_resp_t resp_i,
  input  logic                  rd_chk_i,
  input  logic [31:0]           exp_rdata_i,
  input  logic                  exp_err_i,
  input  logic                  lvl_chk_i,
  input  logic [2:0]            lvl_sel_i,
  input  logic [7:0]            exp_lvl_i,
  input  logic [7:0]            gpio_o_i,
  input  logic [7:0]            gpio_oe_i,
  input  logic                  msip_i,
  input  logic                  irq_i,
  input  logic [1:0]            timer_intr_i,
  output int                    error_cnt_o
);

  logic        pend_q;
  logic        gnt_q;
  logic [31:0] exp_rdata_q;
  logic        exp_err_q;

  function automatic logic [7:0] level_value(input logic [2:0] sel);
    case (sel)
      3'd0:    return gpio_o_i;
      3'd1:    return gpio_oe_i;
      3'd2:    return {7'b0, msip_i};
      3'd3:    return {7'b0, irq_i};
      3'd4:    return {6'b0, timer_intr_i};
      default: return 8'h00;
    endcase
  endfunction

  function automatic string level_name(input logic [2:0] sel);
    case (sel)
      3'd0:    return "gpio_o";
      3'd1:    return "gpio_oe_o";
      3'd2:    return "msip_o";
      3'd3:    return "irq_o";
      3'd4:    return "timer_intr_o";
      default: return "unknown output";
    endcase
  endfunction

  always @(posedge clk_i or negedge rst_n_i) begin
    int          errs;
    logic [7:0]  got;
    errs = 0;
    got  = 8'h00;
    if (!rst_n_i) begin
      pend_q      <= 1'b0;
      gnt_q       <= 1'b0;
      exp_rdata_q <= '0;
      exp_err_q   <= 1'b0;
      error_cnt_o <= 0;
    end else begin
      // Expected values ride along with the granted read
      pend_q      <= rd_chk_i & resp_i.gnt;
      gnt_q       <= req_i & resp_i.gnt;
      exp_rdata_q <= exp_rdata_i;
      exp_err_q   <= exp_err_i;
      // Grant in the request cycle, one response per granted transfer
      if (resp_i.gnt !== req_i) begin
        $display("MISMATCH gnt: expected %h, got %h", req_i, resp_i.gnt);
        errs++;
      end
      if (resp_i.rvalid !== gnt_q) begin
        $display("MISMATCH rvalid: expected %h, got %h", gnt_q, resp_i.rvalid);
        errs++;
      end
      if (pend_q && resp_i.rvalid) begin
        if (resp_i.rdata !== exp_rdata_q) begin
          $display("MISMATCH rdata: expected %h, got %h", exp_rdata_q, resp_i.rdata);
          errs++;
        end
        if (resp_i.err !== exp_err_q) begin
          $display("MISMATCH err: expected %h, got %h", exp_err_q, resp_i.err);
          errs++;
        end
      end
      if (lvl_chk_i) begin
        got = level_value(lvl_sel_i);
        if (got !== exp_lvl_i) begin
          $display("MISMATCH %s: expected %h, got %h", level_name(lvl_sel_i), exp_lvl_i, got);
          errs++;
        end
      end
      error_cnt_o <= error_cnt_o + errs;
    end
  end

endmodule

/* tb_peripheral_subsystem.sv */
// ####################################################################
// Testbench for the peripheral subsystem
// Reads commands from the data file and drives them over OBI and pins
// ####################################################################
`timescale 1ns/100ps

module tb_peripheral_subsystem;

  logic                  clk;
  logic                  rst_n;
  periph_pkg::obi_req_t  obi_req;
  periph_pkg::obi_resp_t obi_resp;
  logic [3:0]            irq_ext;
  logic                  irq;
  logic                  msip;
  logic [7:0]            gpio_in;
  logic [7:0]            gpio_out;
  logic [7:0]            gpio_oe;
  logic [1:0]            timer_intr;

  logic                  rd_chk;
  logic [31:0]           exp_rdata;
  logic                  exp_err;
  logic                  lvl_chk;
  logic [2:0]            lvl_sel;
  logic [7:0]            exp_lvl;
  int                    check_errs;
  int                    seq_errs;
  int                    cycle_cnt;
  int                    cycle_limit;

  byte                   cmd_q[$];
  logic [31:0]           addr_q[$];
  logic [3:0]            be_q[$];
  logic [31:0]           data_q[$];
  logic [31:0]           exp_q[$];

  peripheral_subsystem UUT (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .obi_req_i    (obi_req),
    .obi_resp_o   (obi_resp),
    .irq_ext_i    (irq_ext),
    .irq_o        (irq),
    .msip_o       (msip),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_oe_o    (gpio_oe),
    .timer_intr_o (timer_intr)
  );

  tb_checker checker_i (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .req_i        (obi_req.req),
    .resp_i       (obi_resp),
    .rd_chk_i     (rd_chk),
    .exp_rdata_i  (exp_rdata),
    .exp_err_i    (exp_err),
    .lvl_chk_i    (lvl_chk),
    .lvl_sel_i    (lvl_sel),
    .exp_lvl_i    (exp_lvl),
    .gpio_o_i     (gpio_out),
    .gpio_oe_i    (gpio_oe),
    .msip_i       (msip),
    .irq_i        (irq),
    .timer_intr_i (timer_intr),
    .error_cnt_o  (check_errs)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Output level used as a wait condition while polling
  function automatic logic [7:0] current_level(input logic [2:0] sel);
    case (sel)
      3'd0:    return gpio_out;
      3'd1:    return gpio_oe;
      3'd2:    return {7'b0, msip};
      3'd3:    return {7'b0, irq};
      3'd4:    return {6'b0, timer_intr};
      default: return 8'h00;
    endcase
  endfunction

  task automatic read_command_file();
    int          fd;
    int          n;
    string       line;
    byte         c;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] d;
    logic [31:0] e;
    fd = $fopen("peripheral_testdata.txt", "r");
    if (fd == 0) begin
      $display("Cannot open peripheral_testdata.txt");
      seq_errs++;
      return;
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      if (line.len() < 2 || line.getc(0) == "#") continue;
      n = $sscanf(line, "%c %h %h %h %h", c, a, b, d, e);
      if (n != 5) begin
        $display("Malformed line in data file: %s", line);
        seq_errs++;
        continue;
      end
      cmd_q.push_back(c);
      addr_q.push_back(a);
      be_q.push_back(b[3:0]);
      data_q.push_back(d);
      exp_q.push_back(e);
    end
    $fclose(fd);
  endtask

  // One OBI transfer, returns the read data
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, input logic chk, input logic err_e,
                            input logic [31:0] rdata_e, output logic [31:0] rdata);
    @(negedge clk);
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    rd_chk        = chk;
    exp_err       = err_e;
    exp_rdata     = rdata_e;
    @(posedge clk);
    while (!obi_resp.gnt) @(posedge clk);
    @(negedge clk);
    obi_req.req = 1'b0;
    rd_chk      = 1'b0;
    while (!obi_resp.rvalid) @(negedge clk);
    rdata = obi_resp.rdata;
  endtask

  task automatic poll_read(input logic [31:0] addr, input logic [3:0] be,
                           input logic [31:0] rdata_e);
    logic [31:0] rdata;
    int          tries;
    tries = 0;
    rdata = 32'h0;
    while (tries < 8) begin
      bus_access(1'b0, addr, be, 32'h0, 1'b0, 1'b0, 32'h0, rdata);
      if (rdata == rdata_e) break;
      tries++;
    end
    bus_access(1'b0, addr, be, 32'h0, 1'b1, 1'b0, rdata_e, rdata);
  endtask

  // Waits up to 8 cycles for the level, then has the checker compare it
  task automatic check_level(input logic [2:0] sel, input logic [7:0] level_e);
    int tries;
    tries = 0;
    @(negedge clk);
    while (tries < 8 && current_level(sel) != level_e) begin
      @(negedge clk);
      tries++;
    end
    lvl_chk = 1'b1;
    lvl_sel = sel;
    exp_lvl = level_e;
    @(negedge clk);
    lvl_chk = 1'b0;
  endtask

  task automatic run_command(input int i);
    logic [31:0] rdata;
    case (cmd_q[i])
      "W": bus_access(1'b1, addr_q[i], be_q[i], data_q[i], 1'b0, 1'b0, 32'h0, rdata);
      "R": bus_access(1'b0, addr_q[i], be_q[i], 32'h0, 1'b1, data_q[i][0], exp_q[i], rdata);
      "Q": poll_read(addr_q[i], be_q[i], exp_q[i]);
      "G": gpio_in = data_q[i][7:0];
      "E": irq_ext = data_q[i][3:0];
      "I": check_level(3'd3, exp_q[i][7:0]);
      "T": check_level(3'd4, exp_q[i][7:0]);
      "O": check_level(addr_q[i][2:0], exp_q[i][7:0]);
      default: begin
        $display("Unknown command on data line %0d", i);
        seq_errs++;
      end
    endcase
  endtask

  initial begin
    rst_n       = 1'b0;
    obi_req     = '0;
    irq_ext     = '0;
    gpio_in     = '0;
    rd_chk      = 1'b0;
    exp_rdata   = '0;
    exp_err     = 1'b0;
    lvl_chk     = 1'b0;
    lvl_sel     = '0;
    exp_lvl     = '0;
    seq_errs    = 0;
    read_command_file();
    cycle_limit = cmd_q.size() * 20 + 200;
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < cmd_q.size(); i++) begin
      run_command(i);
    end
    repeat (4) @(negedge clk);
    $display("Error count: %0d check errors, %0d sequence errors", check_errs, seq_errs);
    if (check_errs == 0 && seq_errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    cycle_cnt = 0;
    @(posedge rst_n);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the command sequence did not finish", cycle_cnt);
    $display("Error count: %0d check errors, %0d sequence errors", check_errs, seq_errs + 1);
    $display("Checks failed");
    $finish;
  end

endmodule

/* peripheral_subsystem.f */
periph_pkg.sv
obi_to_reg.sv
reg_decode_demux.sv
irq_ctrl.sv
gpio.sv
cmp_timer.sv
peripheral_subsystem.sv
tb_checker.sv
tb_peripheral_subsystem.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and grade the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_peripheral_subsystem \
  -f peripheral_subsystem.f -o tb_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* peripheral_testdata.txt */
# cmd addr be data exp (hex). W writes data. R reads, data is expected err, exp is rdata
# Q polls a read until exp. G and E drive gpio_i and irq_ext_i. I, T, O expect levels
R 0000020c f 00000000 ffffffff
T 00000000 0 00000000 00000000
I 00000000 0 00000000 00000000
W 00000104 f 000000a5 00000000
R 00000104 f 00000000 000000a5
O 00000000 0 00000000 000000a5
W 00000104 e 0000003c 00000000
R 00000104 f 00000000 000000a5
W 00000108 1 0000005a 00000000
R 00000108 f 00000000 0000005a
O 00000001 0 00000000 0000005a
W 00000004 f 12345678 00000000
W 00000004 2 0000ab00 00000000
R 00000004 f 00000000 0000ab78
W 00000208 3 0000bbcc 00000000
R 00000208 f 00000000 ffffbbcc
R 00000300 f 00000001 00000000
R 00000310 f 00000001 00000000
W 00000004 f 00000000 00000000
W 0000010c f 00000004 00000000
G 00000000 0 00000004 00000000
Q 00000100 f 00000000 00000004
R 00000110 f 00000000 00000004
I 00000000 0 00000000 00000000
W 00000004 f 00000020 00000000
I 00000000 0 00000000 00000001
W 00000110 f 00000004 00000000
R 00000110 f 00000000 00000000
R 00000008 f 00000000 00000005
I 00000000 0 00000000 00000000
W 00000004 f 00005000 00000000
E 00000000 0 0000000a 00000000
I 00000000 0 00000000 00000001
R 00000000 f 00000000 00005000
R 00000008 f 00000000 0000000c
R 00000008 f 00000000 0000000e
R 00000008 f 00000000 00000000
I 00000000 0 00000000 00000000
W 00000204 f 00000064 00000000
W 00000208 f 00000032 00000000
W 0000020c f 000000c8 00000000
T 00000000 0 00000000 00000001
W 00000208 f 00000096 00000000
T 00000000 0 00000000 00000000
R 00000204 f 00000000 00000064
W 0000000c 1 00000001 00000000
O 00000002 0 00000000 00000001
W 0000000c 1 00000000 00000000
O 00000002 0 00000000 00000000
